//--- dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ----------------------------------------
// Cache geometry
// ----------------------------------------

// Byte address width on both CPU and memory sides
`define DCACHE_ADDR_WIDTH 32

`define DCACHE_DATA_WIDTH 32   // Word width

`define DCACHE_LINES 16        // Lines in the direct-mapped store

`define DCACHE_BLOCK_WORDS 4   // Words fetched per refill

`endif

//--- dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    localparam int unsigned BYTE_BITS    = $clog2(`DCACHE_DATA_WIDTH / 8);
    localparam int unsigned INDEX_WIDTH  = $clog2(`DCACHE_LINES);
    localparam int unsigned OFFSET_WIDTH = $clog2(`DCACHE_BLOCK_WORDS);
    localparam int unsigned TAG_WIDTH    =
        `DCACHE_ADDR_WIDTH - BYTE_BITS - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [`DCACHE_ADDR_WIDTH-1:0]   addr_t;       // Byte address
    typedef logic [`DCACHE_DATA_WIDTH-1:0]   data_t;       // Data word
    typedef logic [`DCACHE_DATA_WIDTH/8-1:0] byte_mask_t;  // Write byte enables
    typedef logic [INDEX_WIDTH-1:0]          index_t;      // Line index
    typedef logic [OFFSET_WIDTH-1:0]         offset_t;     // Word in block
    typedef logic [TAG_WIDTH-1:0]            tag_t;        // Upper address bits

    // One word location, offset in the low bits
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } line_ref_t;

    typedef struct packed {
        addr_t      addr;   // Word aligned byte address
        logic       re;     // Read strobe
        logic       we;     // Write strobe
        byte_mask_t be;     // Byte enables for writes
        data_t      wdata;  // Write data
    } mem_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_REFILL_LAST,
        ST_WRITE_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- refill_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module refill_counter
    import dcache_pkg::*;
(
    input  wire logic i_clock,   // Clock
    input  wire logic i_reset,   // Reset
    input  wire logic i_clear,   // Restart at word 0
    input  wire logic i_step,    // Advance one word
    output offset_t   o_offset,  // Current word in block
    output logic      o_last     // Current word is the block's last
);

    offset_t count;

    // Wraps back to word 0 after the last word of a block
    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            count <= '0;
        end else if (i_step) begin
            count <= count + 1'b1;
        end
    end

    assign o_offset = count;
    assign o_last   = (count == offset_t'(`DCACHE_BLOCK_WORDS - 1));

    // The controller restarts and advances the count in separate cycles
    a_clear_step_excl: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_clear && i_step));

endmodule

`default_nettype wire

//--- cache_set.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module cache_set
    import dcache_pkg::*;
(
    input  wire logic      i_clock,       // Clock
    input  wire logic      i_reset,       // Reset

    input  wire line_ref_t i_ref,         // Word being looked up or filled
    input  wire logic      i_fill,        // Write i_wdata into the data store
    input  wire logic      i_last_word,   // Fill completes the block
    input  wire logic      i_invalidate,  // Drop the line at i_ref
    input  wire data_t     i_wdata,       // Fill data from memory

    output data_t          o_rdata,       // Word at i_ref
    output logic           o_hit          // Line valid and tag matches
);

    localparam int unsigned WORDS = `DCACHE_LINES * `DCACHE_BLOCK_WORDS;

    logic [`DCACHE_LINES-1:0]            valid;
    tag_t                                tags  [`DCACHE_LINES];
    data_t                               words [WORDS];
    logic [INDEX_WIDTH+OFFSET_WIDTH-1:0] word_sel;

    assign word_sel = {i_ref.index, i_ref.offset};  // Flat data store address

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid <= '0;
        end else if (i_fill && i_last_word) begin
            valid[i_ref.index] <= 1'b1;  // Whole block now present
        end else if (i_invalidate) begin
            valid[i_ref.index] <= 1'b0;
        end
    end

    // ----------------------------------------
    // Tag and data stores
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_fill && i_last_word) begin
            tags[i_ref.index] <= i_ref.tag;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_fill) begin
            words[word_sel] <= i_wdata;
        end
    end

    // ----------------------------------------
    // Lookup
    // ----------------------------------------

    // Both outputs are asynchronous reads of the stores
    assign o_hit   = valid[i_ref.index] && (tags[i_ref.index] == i_ref.tag);
    assign o_rdata = words[word_sel];

    // Refill and write-through are separate controller phases
    a_fill_inval_excl: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_fill && i_invalidate));

endmodule

`default_nettype wire

//--- dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_controller
    import dcache_pkg::*;
(
    input  wire logic       i_clock,         // Clock
    input  wire logic       i_reset,         // Reset

    input  wire line_ref_t  i_cpu_ref,       // CPU word location
    input  wire logic       i_re,            // CPU read strobe
    input  wire logic       i_we,            // CPU write strobe
    input  wire byte_mask_t i_be,            // CPU byte enables
    input  wire data_t      i_wdata,         // CPU write data

    input  wire logic       i_hit,           // Lookup result at o_access_ref
    input  wire offset_t    i_count_offset,  // Next block word to read
    input  wire logic       i_count_last,    // Reading the last block word

    output line_ref_t       o_access_ref,    // Location for lookup and fill
    output logic            o_fill,          // Store memory data
    output logic            o_invalidate,    // Drop the line on a write hit
    output logic            o_count_clear,   // Restart the word counter
    output logic            o_count_step,    // Advance the word counter
    output mem_req_t        o_mem_req,       // Request to main memory
    output logic            o_busy           // Stall the CPU
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    tag_t        miss_tag;      // Tag of the block being fetched
    index_t      miss_index;    // Line receiving the block
    offset_t     fill_offset;   // Word returned by the previous read
    line_ref_t   read_ref;      // Word address of the read issued now
    logic        start_write;
    logic        start_refill;
    logic        issue_read;
    logic        refilling;

    assign start_write  = (state == ST_IDLE) && i_we;
    assign start_refill = (state == ST_IDLE) && i_re && !i_we && !i_hit;
    assign issue_read   = start_refill || (state == ST_REFILL);
    assign refilling    = (state == ST_REFILL) || (state == ST_REFILL_LAST);

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_write) begin
                    state_next = ST_WRITE_DONE;
                end else if (start_refill) begin
                    state_next = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (i_count_last) begin
                    state_next = ST_REFILL_LAST;  // Last word still to be stored
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // Refill addressing
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (start_refill) begin
            miss_tag   <= i_cpu_ref.tag;
            miss_index <= i_cpu_ref.index;
        end
        if (issue_read) begin
            fill_offset <= i_count_offset;  // Data comes back next cycle
        end
    end

    // The first read leaves straight from the missing CPU address
    always_comb begin
        read_ref.tag    = start_refill ? i_cpu_ref.tag : miss_tag;
        read_ref.index  = start_refill ? i_cpu_ref.index : miss_index;
        read_ref.offset = i_count_offset;
    end

    always_comb begin
        if (refilling) begin
            o_access_ref.tag    = miss_tag;
            o_access_ref.index  = miss_index;
            o_access_ref.offset = fill_offset;
        end else begin
            o_access_ref = i_cpu_ref;
        end
    end

    assign o_fill        = refilling;
    assign o_invalidate  = start_write && i_hit;
    assign o_count_step  = issue_read;
    assign o_count_clear = !issue_read;  // Counter idles at word 0
    assign o_busy        = start_write || start_refill || refilling;

    // ----------------------------------------
    // Memory request
    // ----------------------------------------

    always_comb begin
        o_mem_req.addr  = {(start_write ? i_cpu_ref : read_ref), {BYTE_BITS{1'b0}}};
        o_mem_req.re    = issue_read;
        o_mem_req.we    = start_write;
        o_mem_req.be    = start_write ? i_be : '0;
        o_mem_req.wdata = i_wdata;
    end

    a_mem_rw_excl: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(o_mem_req.re && o_mem_req.we));

    // Every stored word answers a read issued one cycle earlier
    a_fill_after_read: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_fill |-> $past(o_mem_req.re));

endmodule

`default_nettype wire

//--- dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache
    import dcache_pkg::*;
(
    input  wire logic       i_clock,      // Clock
    input  wire logic       i_reset,      // Reset

    // CPU side
    input  wire addr_t      i_addr,       // Byte address
    input  wire logic       i_re,         // Read strobe
    input  wire logic       i_we,         // Write strobe
    input  wire byte_mask_t i_be,         // Byte enables
    input  wire data_t      i_wdata,      // Write data
    output data_t           o_rdata,      // Read data
    output logic            o_busy,       // Stall
    output logic            o_hit,        // Read hit

    // Memory side
    output addr_t           o_mem_addr,   // Byte address
    output logic            o_mem_re,     // Read strobe
    output logic            o_mem_we,     // Write strobe
    output byte_mask_t      o_mem_be,     // Byte enables
    output data_t           o_mem_wdata,  // Write data
    input  wire data_t      i_mem_rdata   // Read data, one cycle after o_mem_re
);

    line_ref_t cpu_ref;
    line_ref_t ctrl_access_ref;
    logic      ctrl_fill;
    logic      ctrl_invalidate;
    logic      ctrl_count_clear;
    logic      ctrl_count_step;
    mem_req_t  ctrl_mem_req;
    offset_t   count_offset;
    logic      count_last;
    logic      set_hit;
    logic      set_last_word;

    assign cpu_ref = i_addr[`DCACHE_ADDR_WIDTH-1:BYTE_BITS];  // Drop byte bits

    assign set_last_word = (ctrl_access_ref.offset == offset_t'(`DCACHE_BLOCK_WORDS - 1));

    assign o_mem_addr  = ctrl_mem_req.addr;
    assign o_mem_re    = ctrl_mem_req.re;
    assign o_mem_we    = ctrl_mem_req.we;
    assign o_mem_be    = ctrl_mem_req.be;
    assign o_mem_wdata = ctrl_mem_req.wdata;

    assign o_hit = set_hit & i_re;  // Only reported for reads

    // ----------------------------------------
    // Controller and word counter
    // ----------------------------------------

    dcache_controller ctrl (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_cpu_ref      (cpu_ref),
        .i_re           (i_re),
        .i_we           (i_we),
        .i_be           (i_be),
        .i_wdata        (i_wdata),
        .i_hit          (set_hit),
        .i_count_offset (count_offset),
        .i_count_last   (count_last),
        .o_access_ref   (ctrl_access_ref),
        .o_fill         (ctrl_fill),
        .o_invalidate   (ctrl_invalidate),
        .o_count_clear  (ctrl_count_clear),
        .o_count_step   (ctrl_count_step),
        .o_mem_req      (ctrl_mem_req),
        .o_busy         (o_busy));

    refill_counter count (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_clear  (ctrl_count_clear),
        .i_step   (ctrl_count_step),
        .o_offset (count_offset),
        .o_last   (count_last));

    // ----------------------------------------
    // Tag and data store
    // ----------------------------------------

    cache_set set (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_ref        (ctrl_access_ref),
        .i_fill       (ctrl_fill),
        .i_last_word  (set_last_word),
        .i_invalidate (ctrl_invalidate),
        .i_wdata      (i_mem_rdata),
        .o_rdata      (o_rdata),
        .o_hit        (set_hit));

endmodule

`default_nettype wire

//--- tb_main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_main_memory
    import dcache_pkg::*;
(
    input  wire logic       i_clock,       // Clock
    input  wire addr_t      i_addr,        // Byte address from the cache
    input  wire logic       i_re,          // Read strobe
    input  wire logic       i_we,          // Write strobe
    input  wire byte_mask_t i_be,          // Byte enables
    input  wire data_t      i_wdata,       // Write data
    input  wire logic       i_load,        // Preload strobe
    input  wire logic [7:0] i_load_index,  // Preload word index
    input  wire data_t      i_load_data,   // Preload word
    output data_t           o_rdata        // Read data, one cycle after i_re
);

    localparam int unsigned DEPTH = 256;  // 1 KiB of words

    data_t      words [DEPTH];
    logic [7:0] word_index;

    assign word_index = i_addr[9:2];  // Wraps every 1 KiB

    always_ff @(posedge i_clock) begin
        if (i_re) begin
            o_rdata <= words[word_index];
        end
    end

    // ----------------------------------------
    // Preload and byte-masked writes
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_load) begin
            words[i_load_index] <= i_load_data;
        end else if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_be[b]) begin
                    words[word_index][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int BLOCK_BYTES = `DCACHE_BLOCK_WORDS * 4;
    localparam int MEM_WORDS   = 256;
    localparam int TIMEOUT     = 20;     // Cycles per request
    localparam int RANDOM_OPS  = 2000;

    logic       clock;
    logic       reset;
    addr_t      cpu_addr;
    logic       cpu_re;
    logic       cpu_we;
    byte_mask_t cpu_be;
    data_t      cpu_wdata;
    data_t      cpu_rdata;
    logic       busy;
    logic       hit;
    addr_t      mem_addr;
    logic       mem_re;
    logic       mem_we;
    byte_mask_t mem_be;
    data_t      mem_wdata;
    data_t      mem_rdata;
    logic       load_we;
    logic [7:0] load_index;
    data_t      load_data;

    logic [7:0]               ref_bytes [MEM_WORDS*4];  // Mirror of main memory
    logic [`DCACHE_LINES-1:0] model_valid;
    tag_t                     model_tag [`DCACHE_LINES];
    logic [31:0]              lfsr;
    int                       errors;
    int                       test_errors;
    int                       tests_run;
    int                       tests_failed;
    logic                     timed_out;

    always #50 clock = ~clock;

    dcache uut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_addr      (cpu_addr),
        .i_re        (cpu_re),
        .i_we        (cpu_we),
        .i_be        (cpu_be),
        .i_wdata     (cpu_wdata),
        .o_rdata     (cpu_rdata),
        .o_busy      (busy),
        .o_hit       (hit),
        .o_mem_addr  (mem_addr),
        .o_mem_re    (mem_re),
        .o_mem_we    (mem_we),
        .o_mem_be    (mem_be),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata));

    tb_main_memory mem (
        .i_clock      (clock),
        .i_addr       (mem_addr),
        .i_re         (mem_re),
        .i_we         (mem_we),
        .i_be         (mem_be),
        .i_wdata      (mem_wdata),
        .i_load       (load_we),
        .i_load_index (load_index),
        .i_load_data  (load_data),
        .o_rdata      (mem_rdata));

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic data_t expected_word(input addr_t addr);
        int base;
        base = int'({addr[9:2], 2'b00});
        return {ref_bytes[base+3], ref_bytes[base+2], ref_bytes[base+1], ref_bytes[base]};
    endfunction

    task automatic apply_write(input addr_t addr, input byte_mask_t be, input data_t wdata);
        int base;
        base = int'({addr[9:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_bytes[base+b] = wdata[8*b +: 8];
            end
        end
    endtask

    function automatic logic predict_hit(input addr_t addr);
        line_ref_t r;
        r = addr[31:2];
        return model_valid[r.index] && (model_tag[r.index] == r.tag);
    endfunction

    task automatic report_error(input string msg);
        $display("** Error @ %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0 || timed_out) begin
            tests_failed++;
        end
        errors += test_errors;
        $display("Test %0d %s: %s (%0d errors)", tests_run, name,
                 (test_errors == 0 && !timed_out) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    task automatic preload_memory();
        logic [31:0] value;
        for (int w = 0; w < MEM_WORDS; w++) begin
            take_bits(32, value);
            for (int b = 0; b < 4; b++) begin
                ref_bytes[w*4+b] = value[8*b +: 8];
            end
            @(negedge clock);
            load_we = 1'b1;
            load_index = 8'(w);
            load_data = value;
        end
        @(negedge clock);
        load_we = 1'b0;
    endtask

    // ----------------------------------------
    // One CPU request checked cycle by cycle
    // ----------------------------------------

    task automatic run_request(input addr_t addr, input logic write, input byte_mask_t be,
                               input data_t wdata, output logic missed);
        int        cycles;
        int        reads;
        int        writes;
        addr_t     base;
        logic      expect_hit;
        line_ref_t r;
        missed = 1'b0;
        if (timed_out) begin
            return;
        end
        r = addr[31:2];
        base = addr & ~addr_t'(BLOCK_BYTES - 1);
        expect_hit = predict_hit(addr);
        cycles = 0;
        reads = 0;
        writes = 0;
        @(negedge clock);
        cpu_addr = addr;
        cpu_re = !write;
        cpu_we = write;
        cpu_be = be;
        cpu_wdata = wdata;
        #25;
        while (busy) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: o_busy stayed high for %0d cycles at address %h",
                         TIMEOUT, addr);
                timed_out = 1'b1;
                return;
            end
            if (hit) begin
                report_error($sformatf("o_hit high while o_busy is high at %h", addr));
            end
            if (mem_re) begin
                if (write || mem_addr != base + addr_t'(reads * 4)) begin
                    report_error($sformatf("refill read %0d at %h, block %h",
                                           reads, mem_addr, base));
                end
                reads++;
            end
            if (mem_we) begin
                if (!write || mem_addr != {addr[31:2], 2'b00} || mem_be != be ||
                    mem_wdata != wdata) begin
                    report_error($sformatf("write strobe addr %h be %b data %h",
                                           mem_addr, mem_be, mem_wdata));
                end
                writes++;
            end
            cycles++;
            @(negedge clock);
            #25;
        end
        if (mem_re || mem_we) begin
            report_error("memory strobe while o_busy is low");
        end
        if (write) begin
            if (cycles != 1 || writes != 1) begin
                report_error($sformatf("write took %0d busy cycles, %0d strobes",
                                       cycles, writes));
            end
            apply_write(addr, be, wdata);
            if (expect_hit) begin
                model_valid[r.index] = 1'b0;  // Write hit drops the line
            end
        end else begin
            missed = (cycles != 0);
            if (cycles != (expect_hit ? 0 : `DCACHE_BLOCK_WORDS + 1) ||
                reads != (expect_hit ? 0 : `DCACHE_BLOCK_WORDS)) begin
                report_error($sformatf("read %h: %0d busy cycles, %0d reads, hit expected %b",
                                       addr, cycles, reads, expect_hit));
            end
            if (!hit) begin
                report_error($sformatf("o_hit low at end of read %h", addr));
            end
            if (cpu_rdata != expected_word(addr)) begin
                report_error($sformatf("read %h gave %h, expected %h",
                                       addr, cpu_rdata, expected_word(addr)));
            end
            model_valid[r.index] = 1'b1;
            model_tag[r.index] = r.tag;
        end
        @(negedge clock);
        cpu_re = 1'b0;
        cpu_we = 1'b0;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic        missed;
        logic        do_write;
        addr_t       addr;
        addr_t       block;
        logic [31:0] bits;
        logic [31:0] value;
        clock = 1'b0;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_re = 1'b0;
        cpu_we = 1'b0;
        cpu_be = '0;
        cpu_wdata = '0;
        load_we = 1'b0;
        load_index = '0;
        load_data = '0;
        model_valid = '0;
        lfsr = 32'he5e93962;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;

        repeat (16) @(negedge clock);
        reset = 1'b0;
        #25;
        if (busy || hit || mem_re || mem_we) begin
            report_error("outputs not idle after reset");
        end
        preload_memory();
        take_bits(8, bits);
        addr = addr_t'({bits[7:0], 2'b00});
        run_request(addr, 1'b0, '0, '0, missed);
        if (!missed) begin
            report_error("first read after reset did not miss");
        end
        finish_test("reset state");

        // Same line with another tag
        block = (addr ^ 32'h100) & ~addr_t'(BLOCK_BYTES - 1);
        run_request(block, 1'b0, '0, '0, missed);
        if (!missed) begin
            report_error("conflicting read did not miss");
        end
        finish_test("read miss refill");

        for (int k = 0; k < `DCACHE_BLOCK_WORDS; k++) begin
            run_request(block + addr_t'(k * 4), 1'b0, '0, '0, missed);
            if (missed) begin
                report_error($sformatf("reread of word %0d missed", k));
            end
        end
        finish_test("read hit");

        addr = (block ^ addr_t'(BLOCK_BYTES)) + 32'h8;  // Neighbouring line that is not cached
        take_bits(4, bits);
        take_bits(32, value);
        run_request(addr, 1'b1, (bits[3:0] == 4'b0000) ? 4'b0101 : bits[3:0], value, missed);
        run_request(addr, 1'b0, '0, '0, missed);
        finish_test("write-through byte mask");

        addr = block + 32'h4;
        take_bits(4, bits);
        take_bits(32, value);
        run_request(addr, 1'b1, bits[3:0] | 4'b0001, value, missed);
        run_request(addr, 1'b0, '0, '0, missed);
        if (!missed) begin
            report_error("read after write hit did not miss");
        end
        finish_test("write-hit invalidation");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            take_bits(2, bits);
            do_write = (bits[1:0] == 2'b00);  // One in four is a write
            take_bits(8, value);
            addr = addr_t'({value[7:0], 2'b00});
            bits = '0;
            value = '0;
            if (do_write) begin
                take_bits(4, bits);
                take_bits(32, value);
            end
            run_request(addr, do_write, bits[3:0], value, missed);
        end
        finish_test("random mix");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
dcache_pkg.sv
refill_counter.sv
cache_set.sv
dcache_controller.sv
dcache.sv
tb_main_memory.sv
tb_dcache.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_dcache
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
